// ==== source/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

	localparam int addr_n = 16;
	localparam int data_n = 8;

	localparam logic [addr_n - 1:0] reset_vector = 16'hfffc;
	localparam logic [data_n - 1:0] stack_page = 8'h01;

	typedef enum logic [3:0] {
		opa_acc, opa_x, opa_y, opa_sp, opa_p,
		opa_dll, opa_dlh, opa_pcl, opa_pch, opa_one
	} opa_sel_t;

	typedef enum logic [1:0] {
		opb_bus, opb_dl, opb_one, opb_zero
	} opb_sel_t;

	typedef enum logic [2:0] {
		addr_pc, addr_dl, addr_stack, addr_vec_lo, addr_vec_hi
	} addr_sel_t;

	// One write enable per destination register
	typedef logic [7:0] dst_t;
	localparam int dst_acc = 0;
	localparam int dst_x = 1;
	localparam int dst_y = 2;
	localparam int dst_sp = 3;
	localparam int dst_p = 4;
	localparam int dst_dl = 5;
	localparam int dst_dll = 6;
	localparam int dst_dlh = 7;

endpackage

// ==== source/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	typedef enum logic [4:0] {
		op_lda,
		op_ldx,
		op_ldy,
		op_sta,
		op_stx,
		op_sty,
		op_adc,
		op_sbc,
		op_and,
		op_ora,
		op_eor,
		op_inx,
		op_iny,
		op_dex,
		op_dey,
		op_tax,
		op_txa,
		op_txs,
		op_clc,
		op_sec,
		op_php,
		op_jmp,
		op_brk
	} opcode_t;

	typedef enum logic [1:0] {
		am_imp,
		am_imm,
		am_abs
	} addressing_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass
	} alu_func_t;

	// Instruction byte, whole or split into aaa bbb cc
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [2:0] aaa;
			logic [2:0] bbb;
			logic [1:0] cc;
		} f;
	} insn_u;

	localparam int status_c = 0;
	localparam int status_z = 1;
	localparam int status_r = 5;
	localparam int status_v = 6;
	localparam int status_n = 7;

endpackage

// ==== source/cpu_if.sv ====
`timescale 1ns/1ns

interface regbus_if import cpu_bus_pkg::*; ();
	opa_sel_t opa;
	opb_sel_t opb;
	dst_t dst;
	logic [data_n - 1:0] flag_upd;
	logic set_c;
	logic clr_c;
	// Reads dlh as zero and clears it
	logic dlh_clr;
	logic [data_n - 1:0] opa_val;
	logic [data_n - 1:0] opb_val;
	logic [data_n - 1:0] p_val;

	modport ctl (output opa, opb, dst, flag_upd, set_c, clr_c, dlh_clr, input p_val);
	modport regs (input opa, opb, dst, flag_upd, set_c, clr_c, dlh_clr,
		output opa_val, opb_val, p_val);
endinterface

interface ctrl_if import cpu_bus_pkg::*; import cpu_isa_pkg::*; ();
	alu_func_t alu_func;
	logic pc_inc;
	logic pc_load;
	logic pc_wel;
	logic pc_weh;
	addr_sel_t addr_sel;
	logic ins_we;

	modport seq (output alu_func, pc_inc, pc_load, pc_wel, pc_weh, addr_sel, ins_we);
	modport pc (input pc_inc, pc_load, pc_wel, pc_weh);
	modport rf (input alu_func);
endinterface

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu import cpu_bus_pkg::*; import cpu_isa_pkg::*; (
	input logic [data_n - 1:0] a_i,
	input logic [data_n - 1:0] b_i,
	input alu_func_t func_i,
	input logic cin_i,
	output logic [data_n - 1:0] res_o,
	output logic cout_o,
	output logic zero_o,
	output logic sign_o,
	output logic ovf_o
);

	logic [data_n - 1:0] b_eff;
	logic [data_n:0] sum;

	// Subtract adds the complement
	assign b_eff = (func_i == alu_sub) ? ~b_i : b_i;
	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {{data_n{1'b0}}, cin_i};

	always_comb begin
		cout_o = cin_i;
		ovf_o = 1'b0;
		case (func_i)
			alu_add, alu_sub: begin
				res_o = sum[data_n - 1:0];
				cout_o = sum[data_n];
				ovf_o = (a_i[data_n - 1] == b_eff[data_n - 1])
					&& (sum[data_n - 1] != a_i[data_n - 1]);
			end
			alu_and: res_o = a_i & b_i;
			alu_or: res_o = a_i | b_i;
			alu_xor: res_o = a_i ^ b_i;
			default: res_o = a_i;
		endcase
	end

	assign zero_o = (res_o == '0);
	assign sign_o = res_o[data_n - 1];

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import cpu_bus_pkg::*; import cpu_isa_pkg::*; #(
	parameter logic [data_n - 1:0] sp_reset = 8'hfd
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic rdy_i,
	regbus_if.regs rb,
	ctrl_if.rf ctl,
	input logic [data_n - 1:0] data_i,
	input logic [data_n - 1:0] alu_res_i,
	input logic alu_c_i,
	input logic alu_z_i,
	input logic alu_n_i,
	input logic alu_v_i,
	input logic [data_n - 1:0] pcl_i,
	input logic [data_n - 1:0] pch_i,
	output logic [data_n - 1:0] sp_o,
	output logic [data_n - 1:0] dll_o,
	output logic [data_n - 1:0] dlh_o,
	output logic c_o
);

	logic [data_n - 1:0] acc, x, y, sp, p;
	logic [data_n - 1:0] dl, dll, dlh;
	logic [data_n - 1:0] p_new, p_next;

	always_comb begin
		case (rb.opa)
			opa_acc: rb.opa_val = acc;
			opa_x: rb.opa_val = x;
			opa_y: rb.opa_val = y;
			opa_sp: rb.opa_val = sp;
			opa_p: rb.opa_val = p;
			opa_dll: rb.opa_val = dll;
			opa_dlh: rb.opa_val = rb.dlh_clr ? '0 : dlh;
			opa_pcl: rb.opa_val = pcl_i;
			opa_pch: rb.opa_val = pch_i;
			default: rb.opa_val = data_n'(1);
		endcase
		case (rb.opb)
			opb_bus: rb.opb_val = data_i;
			opb_dl: rb.opb_val = dl;
			opb_one: rb.opb_val = data_n'(1);
			default: rb.opb_val = '0;
		endcase
	end

	// Flag merge, carry overrides last
	always_comb begin
		p_new = '0;
		p_new[status_c] = alu_c_i;
		p_new[status_z] = alu_z_i;
		p_new[status_v] = alu_v_i;
		p_new[status_n] = alu_n_i;
		p_next = (p & ~rb.flag_upd) | (p_new & rb.flag_upd);
		if (rb.dst[dst_p])
			p_next = alu_res_i;
		if (rb.set_c)
			p_next[status_c] = 1'b1;
		if (rb.clr_c)
			p_next[status_c] = 1'b0;
		p_next[status_r] = 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			acc <= '0;
			x <= '0;
			y <= '0;
			sp <= sp_reset;
			p <= data_n'(1) << status_r;
		end else if (rdy_i) begin
			if (rb.dst[dst_acc])
				acc <= alu_res_i;
			if (rb.dst[dst_x])
				x <= alu_res_i;
			if (rb.dst[dst_y])
				y <= alu_res_i;
			if (rb.dst[dst_sp])
				sp <= alu_res_i;
			p <= p_next;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rdy_i) begin
			if (rb.dst[dst_dl])
				dl <= alu_res_i;
			if (rb.dst[dst_dll])
				dll <= alu_res_i;
			if (rb.dst[dst_dlh])
				dlh <= alu_res_i;
			else if (rb.dlh_clr)
				dlh <= '0;
		end
	end

	// Increment and decrement through B = 1 need a fixed carry in
	assign c_o = (rb.opb == opb_one) ? (ctl.alu_func == alu_sub) : p[status_c];

	assign rb.p_val = p;
	assign sp_o = sp;
	assign dll_o = dll;
	assign dlh_o = dlh;

	p_reserved_set: assert property (@(posedge clk_i) rst_n_i |-> p[status_r]);

endmodule

// ==== source/pc.sv ====
`timescale 1ns/1ns

module pc import cpu_bus_pkg::*; (
	input logic clk_i,
	input logic rst_n_i,
	input logic rdy_i,
	ctrl_if.pc ctl,
	input logic [data_n - 1:0] res_i,
	input logic [addr_n - 1:0] load_i,
	output logic [addr_n - 1:0] pc_o
);

	logic [addr_n - 1:0] pc_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (rdy_i) begin
			if (ctl.pc_load)
				pc_q <= load_i;
			else if (ctl.pc_wel)
				pc_q[data_n - 1:0] <= res_i;
			else if (ctl.pc_weh)
				pc_q[addr_n - 1:data_n] <= res_i;
			else if (ctl.pc_inc)
				pc_q <= pc_q + 1'b1;
		end
	end

	assign pc_o = pc_q;

	inc_load_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(ctl.pc_inc && ctl.pc_load));

endmodule

// ==== source/idec.sv ====
`timescale 1ns/1ns

module idec import cpu_isa_pkg::*; (
	input insn_u insn_i,
	output opcode_t opcode_o,
	output addressing_t mode_o,
	output alu_func_t func_o
);

	always_comb begin
		case (insn_i.raw)
			8'ha9, 8'had: opcode_o = op_lda;
			8'ha2, 8'hae: opcode_o = op_ldx;
			8'ha0, 8'hac: opcode_o = op_ldy;
			8'h8d: opcode_o = op_sta;
			8'h8e: opcode_o = op_stx;
			8'h8c: opcode_o = op_sty;
			8'h69, 8'h6d: opcode_o = op_adc;
			8'he9, 8'hed: opcode_o = op_sbc;
			8'h29, 8'h2d: opcode_o = op_and;
			8'h09, 8'h0d: opcode_o = op_ora;
			8'h49, 8'h4d: opcode_o = op_eor;
			8'he8: opcode_o = op_inx;
			8'hc8: opcode_o = op_iny;
			8'hca: opcode_o = op_dex;
			8'h88: opcode_o = op_dey;
			8'haa: opcode_o = op_tax;
			8'h8a: opcode_o = op_txa;
			8'h9a: opcode_o = op_txs;
			8'h18: opcode_o = op_clc;
			8'h38: opcode_o = op_sec;
			8'h08: opcode_o = op_php;
			8'h4c: opcode_o = op_jmp;
			default: opcode_o = op_brk;
		endcase
	end

	// bbb selects the mode, immediate sits at 010 for cc=01 and 000 otherwise
	always_comb begin
		if (opcode_o == op_brk)
			mode_o = am_imp;
		else if (insn_i.f.bbb == 3'b011)
			mode_o = am_abs;
		else if ((insn_i.f.cc == 2'b01 && insn_i.f.bbb == 3'b010)
				|| (insn_i.f.cc != 2'b01 && insn_i.f.bbb == 3'b000 && insn_i.f.aaa[2]))
			mode_o = am_imm;
		else
			mode_o = am_imp;
	end

	always_comb begin
		case (insn_i.f.aaa)
			3'b000: func_o = alu_or;
			3'b001: func_o = alu_and;
			3'b010: func_o = alu_xor;
			3'b011: func_o = alu_add;
			3'b111: func_o = alu_sub;
			default: func_o = alu_pass;
		endcase
	end

endmodule

// ==== source/sequencer.sv ====
`timescale 1ns/1ns

module sequencer import cpu_bus_pkg::*; import cpu_isa_pkg::*; (
	input logic clk_i,
	input logic rst_n_i,
	input logic rdy_i,
	input opcode_t opcode_i,
	input addressing_t mode_i,
	input alu_func_t func_i,
	regbus_if.ctl rb,
	ctrl_if.seq ctl,
	output logic we_o,
	output logic dbg_o
);

	typedef enum logic [2:0] {
		st_vector, st_fetch, st_first, st_operand,
		st_execute, st_write, st_push, st_halt
	} state_t;

	localparam logic [data_n - 1:0] flags_nz =
		(data_n'(1) << status_n) | (data_n'(1) << status_z);
	localparam logic [data_n - 1:0] flags_nzcv =
		flags_nz | (data_n'(1) << status_c) | (data_n'(1) << status_v);

	state_t state, state_next;
	logic step;
	logic data_cycle;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state <= st_vector;
			step <= 1'b0;
		end else if (rdy_i) begin
			state <= state_next;
			step <= (state == st_vector) ? !step : 1'b0;
		end
	end

	always_comb begin
		state_next = state;
		data_cycle = 1'b0;
		rb.opa = opa_dlh;
		rb.opb = opb_bus;
		rb.dst = '0;
		rb.flag_upd = '0;
		rb.set_c = 1'b0;
		rb.clr_c = 1'b0;
		rb.dlh_clr = 1'b0;
		ctl.alu_func = alu_or;
		ctl.pc_inc = 1'b0;
		ctl.pc_load = 1'b0;
		ctl.pc_wel = 1'b0;
		ctl.pc_weh = 1'b0;
		ctl.addr_sel = addr_pc;
		ctl.ins_we = 1'b0;
		case (state)
			st_vector: begin
				// Vector byte goes straight into the PC
				rb.dlh_clr = 1'b1;
				ctl.addr_sel = step ? addr_vec_hi : addr_vec_lo;
				ctl.pc_wel = !step;
				ctl.pc_weh = step;
				if (step)
					state_next = st_fetch;
			end
			st_fetch: begin
				ctl.ins_we = 1'b1;
				ctl.pc_inc = 1'b1;
				state_next = st_first;
			end
			st_first: begin
				state_next = st_fetch;
				case (mode_i)
					am_imm: begin
						ctl.pc_inc = 1'b1;
						data_cycle = 1'b1;
					end
					am_abs: begin
						rb.dlh_clr = 1'b1;
						rb.dst[dst_dll] = 1'b1;
						rb.dst[dst_dl] = 1'b1;
						ctl.pc_inc = 1'b1;
						state_next = st_operand;
					end
					default: begin
						case (opcode_i)
							op_inx, op_iny, op_dex, op_dey: begin
								rb.opa = (opcode_i == op_inx || opcode_i == op_dex) ? opa_x : opa_y;
								rb.opb = opb_one;
								ctl.alu_func = (opcode_i == op_inx || opcode_i == op_iny)
									? alu_add : alu_sub;
								rb.dst[dst_x] = (rb.opa == opa_x);
								rb.dst[dst_y] = (rb.opa == opa_y);
								rb.flag_upd = flags_nz;
							end
							op_tax: begin
								rb.opa = opa_acc;
								ctl.alu_func = alu_pass;
								rb.dst[dst_x] = 1'b1;
								rb.flag_upd = flags_nz;
							end
							op_txa, op_txs: begin
								rb.opa = opa_x;
								ctl.alu_func = alu_pass;
								rb.dst[dst_acc] = (opcode_i == op_txa);
								rb.dst[dst_sp] = (opcode_i == op_txs);
								rb.flag_upd = (opcode_i == op_txa) ? flags_nz : '0;
							end
							op_clc: rb.clr_c = 1'b1;
							op_sec: rb.set_c = 1'b1;
							op_php: begin
								rb.opa = opa_p;
								ctl.alu_func = alu_pass;
								ctl.addr_sel = addr_stack;
								state_next = st_push;
							end
							default: state_next = st_halt;
						endcase
					end
				endcase
			end
			st_operand: begin
				if (opcode_i == op_jmp) begin
					ctl.pc_load = 1'b1;
					state_next = st_fetch;
				end else begin
					rb.dlh_clr = 1'b1;
					rb.dst[dst_dlh] = 1'b1;
					ctl.pc_inc = 1'b1;
					if (opcode_i == op_sta || opcode_i == op_stx || opcode_i == op_sty)
						state_next = st_write;
					else
						state_next = st_execute;
				end
			end
			st_execute: begin
				ctl.addr_sel = addr_dl;
				data_cycle = 1'b1;
				state_next = st_fetch;
			end
			st_write: begin
				ctl.addr_sel = addr_dl;
				ctl.alu_func = alu_pass;
				if (opcode_i == op_stx)
					rb.opa = opa_x;
				else if (opcode_i == op_sty)
					rb.opa = opa_y;
				else
					rb.opa = opa_acc;
				state_next = st_fetch;
			end
			st_push: begin
				rb.opa = opa_sp;
				rb.opb = opb_one;
				ctl.alu_func = alu_sub;
				rb.dst[dst_sp] = 1'b1;
				state_next = st_fetch;
			end
			default: state_next = st_halt;
		endcase

		// Operation on the bus byte, immediate or absolute
		if (data_cycle) begin
			case (opcode_i)
				op_lda, op_ldx, op_ldy: begin
					rb.dlh_clr = 1'b1;
					rb.dst[dst_acc] = (opcode_i == op_lda);
					rb.dst[dst_x] = (opcode_i == op_ldx);
					rb.dst[dst_y] = (opcode_i == op_ldy);
					rb.flag_upd = flags_nz;
				end
				default: begin
					rb.opa = opa_acc;
					ctl.alu_func = func_i;
					rb.dst[dst_acc] = 1'b1;
					rb.flag_upd = (func_i == alu_add || func_i == alu_sub) ? flags_nzcv : flags_nz;
				end
			endcase
		end
	end

	assign we_o = (state == st_write)
		|| (state == st_first && mode_i == am_imp && opcode_i == op_php);
	assign dbg_o = (state == st_halt);

	no_write_halted: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dbg_o |-> !we_o);

endmodule

// ==== source/cpu.sv ====
`timescale 1ns/1ns

module cpu import cpu_bus_pkg::*; import cpu_isa_pkg::*; #(
	parameter logic [data_n - 1:0] sp_reset = 8'hfd
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic rdy_i,
	input logic [data_n - 1:0] data_i,
	output logic we_o,
	output logic dbg_o,
	output logic [addr_n - 1:0] addr_o,
	output logic [data_n - 1:0] data_o
);

	regbus_if rb ();
	ctrl_if ctl ();

	insn_u ir;
	logic [data_n - 1:0] alu_res, sp, dll, dlh;
	logic alu_c, alu_z, alu_n, alu_v, alu_cin;
	logic [addr_n - 1:0] pc_val;
	opcode_t opcode;
	addressing_t mode;
	alu_func_t dec_func;

	// Instruction register
	always_ff @(posedge clk_i) begin
		if (rdy_i && ctl.ins_we)
			ir.raw <= data_i;
	end

	alu alu0 (.a_i(rb.opa_val), .b_i(rb.opb_val), .func_i(ctl.alu_func), .cin_i(alu_cin),
		.res_o(alu_res), .cout_o(alu_c), .zero_o(alu_z), .sign_o(alu_n), .ovf_o(alu_v));

	reg_file #(.sp_reset(sp_reset)) rf0 (.clk_i, .rst_n_i, .rdy_i, .rb(rb.regs), .ctl(ctl.rf),
		.data_i, .alu_res_i(alu_res), .alu_c_i(alu_c), .alu_z_i(alu_z), .alu_n_i(alu_n),
		.alu_v_i(alu_v), .pcl_i(pc_val[data_n - 1:0]), .pch_i(pc_val[addr_n - 1:data_n]),
		.sp_o(sp), .dll_o(dll), .dlh_o(dlh), .c_o(alu_cin));

	pc pc0 (.clk_i, .rst_n_i, .rdy_i, .ctl(ctl.pc), .res_i(alu_res),
		.load_i({data_i, dll}), .pc_o(pc_val));

	idec idec0 (.insn_i(ir), .opcode_o(opcode), .mode_o(mode), .func_o(dec_func));

	sequencer seq0 (.clk_i, .rst_n_i, .rdy_i, .opcode_i(opcode), .mode_i(mode),
		.func_i(dec_func), .rb(rb.ctl), .ctl(ctl.seq), .we_o, .dbg_o);

	always_comb begin
		case (ctl.addr_sel)
			addr_dl: addr_o = {dlh, dll};
			addr_stack: addr_o = {stack_page, sp};
			addr_vec_lo: addr_o = reset_vector;
			addr_vec_hi: addr_o = reset_vector + 1'b1;
			default: addr_o = pc_val;
		endcase
	end

	assign data_o = alu_res;

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import cpu_bus_pkg::*; import cpu_isa_pkg::*; ();

	localparam int n_rows = 17;
	localparam int n_runs = 2 * n_rows;
	localparam int cycles_per_run = 300;
	localparam logic [addr_n - 1:0] code_base = 16'h0600;
	localparam logic [addr_n - 1:0] jump_base = 16'h0400;
	localparam logic [addr_n - 1:0] operand_addr = 16'h0200;
	localparam logic [addr_n - 1:0] result_addr = 16'h0300;
	localparam logic [addr_n - 1:0] skipped_addr = 16'h0310;

	typedef struct {
		string name;
		insn_u op;
		logic cin;
		logic [data_n - 1:0] a;
		logic [data_n - 1:0] b;
		addressing_t mode;
		logic [data_n - 1:0] exp_res;
		logic [data_n - 1:0] exp_p;
	} row_t;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic rdy = 1'b1;
	logic stall_en = 1'b0;
	logic we, dbg;
	logic [addr_n - 1:0] addr;
	logic [data_n - 1:0] rd_data, wr_data;

	logic [data_n - 1:0] mem [0:(1 << addr_n) - 1];
	logic [addr_n - 1:0] wr_addr_q[$];
	logic [data_n - 1:0] wr_data_q[$];
	row_t rows [n_rows];
	logic [addr_n - 1:0] load_ptr;

	cpu #(.sp_reset(8'hfd)) dut0 (
		.clk_i(clk), .rst_n_i(rst_n), .rdy_i(rdy), .data_i(rd_data),
		.we_o(we), .dbg_o(dbg), .addr_o(addr), .data_o(wr_data));

	always #5 clk = ~clk;

	// Memory answers reads in the same cycle
	assign rd_data = mem[addr];

	always @(posedge clk) begin
		if (stall_en)
			rdy <= ($urandom % 4) != 0;
		else
			rdy <= 1'b1;
	end

	// A write only counts on a ready edge
	always @(posedge clk) begin
		if (rst_n && rdy && we) begin
			wr_addr_q.push_back(addr);
			wr_data_q.push_back(wr_data);
		end
	end

	task automatic end_with_failure(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [data_n - 1:0] exp,
		input logic [data_n - 1:0] act);
		if (act !== exp)
			end_with_failure($sformatf("MISMATCH %s: expected %02h, actual %02h",
				name, exp, act));
	endtask

	task automatic check_addr(input string name, input logic [addr_n - 1:0] exp,
		input logic [addr_n - 1:0] act);
		if (act !== exp)
			end_with_failure($sformatf("MISMATCH %s: expected %04h, actual %04h",
				name, exp, act));
	endtask

	task automatic check_status(input string name, input logic [data_n - 1:0] exp,
		input logic [data_n - 1:0] act);
		logic [data_n - 1:0] mask;
		mask = '0;
		mask[status_c] = 1'b1;
		mask[status_z] = 1'b1;
		mask[status_r] = 1'b1;
		mask[status_v] = 1'b1;
		mask[status_n] = 1'b1;
		if ((act & mask) !== (exp & mask))
			end_with_failure($sformatf("MISMATCH %s: expected %02h, actual %02h",
				name, exp & mask, act & mask));
	endtask

	// Reference model of the tested operation and its flags
	task automatic predict(input logic [7:0] op, input logic cin,
		input logic [data_n - 1:0] a, input logic [data_n - 1:0] b,
		output logic [data_n - 1:0] res, output logic [data_n - 1:0] p);
		int s;
		logic c;
		logic v;
		c = cin;
		v = 1'b0;
		case (op)
			8'h69, 8'h6d, 8'h4c: begin
				s = int'(a) + int'(b) + int'(cin);
				res = s[7:0];
				c = s > 255;
				v = (a[7] == b[7]) && (res[7] != a[7]);
			end
			8'he9, 8'hed: begin
				// Carry clear means borrow
				s = int'(a) - int'(b) - (cin ? 0 : 1);
				res = s[7:0];
				c = s >= 0;
				v = (a[7] != b[7]) && (res[7] != a[7]);
			end
			8'h29, 8'h2d: res = a & b;
			8'h09, 8'h0d: res = a | b;
			8'h49, 8'h4d: res = a ^ b;
			8'haa: res = a;
			8'h8a: res = b;
			8'he8, 8'hc8: res = b + 8'd1;
			default: res = b - 8'd1;
		endcase
		p = '0;
		p[status_c] = c;
		p[status_z] = (res == 8'h00);
		p[status_r] = 1'b1;
		p[status_v] = v;
		p[status_n] = res[7];
	endtask

	task automatic set_row(input int i, input string name, input logic [7:0] op,
		input logic cin, input logic [data_n - 1:0] a, input logic [data_n - 1:0] b,
		input addressing_t mode);
		logic [data_n - 1:0] res, p;
		predict(op, cin, a, b, res, p);
		rows[i].name = name;
		rows[i].op.raw = op;
		rows[i].cin = cin;
		rows[i].a = a;
		rows[i].b = b;
		rows[i].mode = mode;
		rows[i].exp_res = res;
		rows[i].exp_p = p;
	endtask

	// name, opcode, carry in, A, B, mode
	task automatic load_table();
		set_row(0, "adc_imm", 8'h69, 1'b0, 8'h50, 8'h50, am_imm);
		set_row(1, "adc_abs", 8'h6d, 1'b1, 8'hff, 8'h00, am_abs);
		set_row(2, "sbc_imm", 8'he9, 1'b1, 8'h50, 8'hf0, am_imm);
		set_row(3, "sbc_abs", 8'hed, 1'b0, 8'h80, 8'h01, am_abs);
		set_row(4, "and_imm", 8'h29, 1'b1, 8'hf0, 8'h0f, am_imm);
		set_row(5, "and_abs", 8'h2d, 1'b0, 8'hc3, 8'h81, am_abs);
		set_row(6, "ora_imm", 8'h09, 1'b0, 8'h00, 8'h00, am_imm);
		set_row(7, "ora_abs", 8'h0d, 1'b1, 8'h12, 8'h84, am_abs);
		set_row(8, "eor_imm", 8'h49, 1'b0, 8'hff, 8'h0f, am_imm);
		set_row(9, "eor_abs", 8'h4d, 1'b1, 8'h5a, 8'h5a, am_abs);
		set_row(10, "tax", 8'haa, 1'b0, 8'h80, 8'h11, am_imp);
		set_row(11, "txa", 8'h8a, 1'b1, 8'h22, 8'h00, am_imp);
		set_row(12, "inx", 8'he8, 1'b0, 8'h00, 8'hff, am_imp);
		set_row(13, "dex", 8'hca, 1'b1, 8'h00, 8'h00, am_imp);
		set_row(14, "iny", 8'hc8, 1'b0, 8'h00, 8'h7f, am_imp);
		set_row(15, "dey", 8'h88, 1'b1, 8'h00, 8'h01, am_imp);
		set_row(16, "jmp", 8'h4c, 1'b1, 8'h10, 8'h20, am_abs);
	endtask

	task automatic emit(input logic [data_n - 1:0] b);
		mem[load_ptr] = b;
		load_ptr = load_ptr + 16'd1;
	endtask

	task automatic emit_abs(input logic [data_n - 1:0] op, input logic [addr_n - 1:0] a);
		emit(op);
		emit(a[7:0]);
		emit(a[15:8]);
	endtask

	function automatic logic [7:0] store_opcode(input logic [7:0] op);
		case (op)
			8'haa, 8'he8, 8'hca: return 8'h8e;
			8'hc8, 8'h88: return 8'h8c;
			default: return 8'h8d;
		endcase
	endfunction

	task automatic build_program(input row_t r);
		for (int i = 0; i < (1 << addr_n); i++)
			mem[i] = i[15:8] ^ i[7:0] ^ 8'h3c;
		mem[reset_vector] = code_base[7:0];
		mem[reset_vector + 1] = code_base[15:8];
		mem[operand_addr] = r.b;
		load_ptr = code_base;
		emit(8'ha9);
		emit(r.a);
		emit(r.cin ? 8'h38 : 8'h18);
		if (r.op.raw == 8'h4c) begin
			// Store behind the JMP is dead code
			emit_abs(8'h4c, jump_base);
			emit_abs(8'h8d, skipped_addr);
			load_ptr = jump_base;
			emit(8'h69);
			emit(r.b);
			emit_abs(8'h8d, result_addr);
		end else if (r.mode == am_imp) begin
			emit(8'ha2);
			emit(r.b);
			emit(8'ha0);
			emit(r.b);
			emit(r.op.raw);
			emit_abs(store_opcode(r.op.raw), result_addr);
		end else begin
			if (r.mode == am_imm) begin
				emit(r.op.raw);
				emit(r.b);
			end else begin
				emit_abs(r.op.raw, operand_addr);
			end
			emit_abs(8'h8d, result_addr);
		end
		emit(8'h08);
		emit(8'h00);
	endtask

	task automatic run_row(input row_t r, input logic stalled);
		string tag;
		tag = stalled ? {r.name, "/stall"} : r.name;
		stall_en = stalled;
		build_program(r);
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		wr_addr_q.delete();
		wr_data_q.delete();
		rst_n <= 1'b1;
		@(negedge clk);
		check_addr({tag, " reset address"}, reset_vector, addr);
		if (we !== 1'b0 || dbg !== 1'b0)
			end_with_failure({tag, ": we_o or dbg_o is not low right after reset"});
		while (dbg !== 1'b1)
			@(negedge clk);
		repeat (20) begin
			@(negedge clk);
			if (dbg !== 1'b1 || we !== 1'b0)
				end_with_failure({tag, ": core left the halt state after BRK"});
		end
		if (wr_addr_q.size() != 2)
			end_with_failure($sformatf("%s: expected 2 bus writes but saw %0d",
				tag, wr_addr_q.size()));
		check_addr({tag, " store address"}, result_addr, wr_addr_q[0]);
		check_data({tag, " result"}, r.exp_res, wr_data_q[0]);
		check_addr({tag, " push address"}, {stack_page, 8'hfd}, wr_addr_q[1]);
		check_status({tag, " status"}, r.exp_p, wr_data_q[1]);
	endtask

	initial begin
		void'($urandom(32'hfc9c));
		load_table();
		// First pass without stalls, second with random rdy
		for (int pass = 0; pass < 2; pass++)
			for (int i = 0; i < n_rows; i++)
				run_row(rows[i], pass == 1);
		$display("=== PASS ===");
		$finish;
	end

	initial begin
		#(n_runs * cycles_per_run * 10);
		end_with_failure("timeout: the core never halted in the allowed time");
	end

endmodule

// ==== cpu.f ====
source/cpu_bus_pkg.sv
source/cpu_isa_pkg.sv
source/cpu_if.sv
source/alu.sv
source/reg_file.sv
source/pc.sv
source/idec.sv
source/sequencer.sv
source/cpu.sv
bench/cpu_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build cpu_tb with Verilator, run it into $(LOG), check for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f -o cpu_sim
	./obj_dir/cpu_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
